//--- design/gauss_filter.sv
`default_nettype none

`include "img_filter_defs.svh"

module gauss_filter (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire img_filter_pkg::window_t i_window,
    input  wire                          i_load,
    input  wire                          i_last,
    output img_filter_pkg::result_t      o_res
);

    // The kernel weights add up to 16, so four extra bits hold the full sum.
    localparam int SUM_W = `PIX_W + 4;

    logic [SUM_W-1:0] corner_sum;
    logic [SUM_W-1:0] edge_sum;
    logic [SUM_W-1:0] sum;

    logic [`PIX_W-1:0] data_q;
    logic              last_q;

    assign corner_sum = SUM_W'(i_window.p00) + SUM_W'(i_window.p02) +
                        SUM_W'(i_window.p20) + SUM_W'(i_window.p22);

    assign edge_sum = SUM_W'(i_window.p01) + SUM_W'(i_window.p10) +
                      SUM_W'(i_window.p12) + SUM_W'(i_window.p21);

    assign sum = corner_sum + (edge_sum << 1) + (SUM_W'(i_window.p11) << 2);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_q <= 1'b0;
        end else if (i_load) begin
            last_q <= i_last;
        end
    end

    // Divide by 16 and truncate.
    always_ff @(posedge clk) begin
        if (i_load) begin
            data_q <= sum[SUM_W-1:4];
        end
    end

    assign o_res.data = data_q;
    assign o_res.last = last_q;

endmodule

`default_nettype wire

//--- design/img_filter_defs.svh
`ifndef IMG_FILTER_DEFS_SVH
`define IMG_FILTER_DEFS_SVH

// Image geometry. Both sizes must be at least 3 so that a full 3x3 window
// fits inside the frame.
`define IMG_COLS 8
`define IMG_ROWS 6

// Grayscale pixel width.
`define PIX_W 8

// Width of the column and row counters.
`define CNT_W 10

`endif

//--- design/img_filter_pkg.sv
`default_nettype none

`include "img_filter_defs.svh"

package img_filter_pkg;

    typedef logic [`PIX_W-1:0] pixel_t;

    // One column of the window. bot is the newest row.
    typedef struct packed {
        pixel_t top;
        pixel_t mid;
        pixel_t bot;
    } col_taps_t;

    // Row first; p22 is the most recent pixel.
    typedef struct packed {
        pixel_t p00;
        pixel_t p01;
        pixel_t p02;
        pixel_t p10;
        pixel_t p11;
        pixel_t p12;
        pixel_t p20;
        pixel_t p21;
        pixel_t p22;
    } window_t;

    typedef struct packed {
        pixel_t data;
        logic   last;
    } result_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_STEP,
        S_FILT,
        S_RES,
        S_RES_DROP,
        S_ACK
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- design/img_filter_top.sv
`default_nettype none

`include "img_filter_defs.svh"

module img_filter_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     i_pix_req,
    input  wire  [`PIX_W-1:0]       i_pix,
    output logic                    o_pix_ack,
    output logic                    o_res_req,
    output img_filter_pkg::result_t o_res,
    input  wire                     i_res_ack
);

    logic                      advance;
    logic                      filt_load;
    logic                      win_valid;
    logic                      frame_last;
    img_filter_pkg::col_taps_t taps;
    img_filter_pkg::window_t   window;

    line_buffer u_line_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_advance (advance),
        .i_pix     (i_pix),
        .o_taps    (taps)
    );

    window_datapath u_window_datapath (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_advance    (advance),
        .i_taps       (taps),
        .o_window     (window),
        .o_win_valid  (win_valid),
        .o_frame_last (frame_last)
    );

    gauss_filter u_gauss_filter (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_window (window),
        .i_load   (filt_load),
        .i_last   (frame_last),
        .o_res    (o_res)
    );

    window_ctrl u_window_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_pix_req    (i_pix_req),
        .o_pix_ack    (o_pix_ack),
        .i_win_valid  (win_valid),
        .i_frame_last (frame_last),
        .o_advance    (advance),
        .o_filt_load  (filt_load),
        .o_res_req    (o_res_req),
        .i_res_ack    (i_res_ack)
    );

endmodule

`default_nettype wire

//--- design/line_buffer.sv
`default_nettype none

`include "img_filter_defs.svh"

module line_buffer (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            i_advance,
    input  wire  [`PIX_W-1:0]              i_pix,
    output img_filter_pkg::col_taps_t      o_taps
);

    localparam int PTR_W = $clog2(`IMG_COLS);

    // line0_mem holds the previous row, line1_mem the row before that.
    logic [`PIX_W-1:0] line0_mem [`IMG_COLS];
    logic [`PIX_W-1:0] line1_mem [`IMG_COLS];

    logic [PTR_W-1:0] ptr_q;

    img_filter_pkg::col_taps_t taps_q;

    // The pointer tracks the column, so reset also realigns it to a new frame.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr_q <= '0;
        end else if (i_advance) begin
            if (ptr_q == PTR_W'(`IMG_COLS - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= ptr_q + 1'b1;
            end
        end
    end

    // On advance the column shifts up one row: the new pixel goes into the
    // first line and the value it replaces moves into the second.
    always_ff @(posedge clk) begin
        if (i_advance) begin
            line0_mem[ptr_q] <= i_pix;
            line1_mem[ptr_q] <= line0_mem[ptr_q];
        end
    end

    // The taps are read every cycle.  While a request waits in idle the pixel
    // and the pointer are stable, so the taps are settled by the advance.
    always_ff @(posedge clk) begin
        taps_q.top <= line1_mem[ptr_q];
        taps_q.mid <= line0_mem[ptr_q];
        taps_q.bot <= i_pix;
    end

    assign o_taps = taps_q;

endmodule

`default_nettype wire

//--- design/window_ctrl.sv
`default_nettype none

module window_ctrl (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  i_pix_req,
    output logic o_pix_ack,
    input  wire  i_win_valid,
    input  wire  i_frame_last,
    output logic o_advance,
    output logic o_filt_load,
    output logic o_res_req,
    input  wire  i_res_ack
);

    img_filter_pkg::ctrl_state_e state_q;
    img_filter_pkg::ctrl_state_e state_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= img_filter_pkg::S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            img_filter_pkg::S_IDLE: begin
                if (i_pix_req) begin
                    state_d = img_filter_pkg::S_STEP;
                end
            end
            img_filter_pkg::S_STEP: begin
                state_d = img_filter_pkg::S_FILT;
            end
            // The window flags are registered by the advance, so they are
            // current here.
            img_filter_pkg::S_FILT: begin
                if (i_win_valid) begin
                    state_d = img_filter_pkg::S_RES;
                end else begin
                    state_d = img_filter_pkg::S_ACK;
                end
            end
            img_filter_pkg::S_RES: begin
                if (i_res_ack) begin
                    state_d = img_filter_pkg::S_RES_DROP;
                end
            end
            img_filter_pkg::S_RES_DROP: begin
                if (!i_res_ack) begin
                    state_d = img_filter_pkg::S_ACK;
                end
            end
            img_filter_pkg::S_ACK: begin
                if (!i_pix_req) begin
                    state_d = img_filter_pkg::S_IDLE;
                end
            end
            default: begin
                state_d = img_filter_pkg::S_IDLE;
            end
        endcase
    end

    assign o_advance   = (state_q == img_filter_pkg::S_STEP);
    assign o_filt_load = (state_q == img_filter_pkg::S_FILT);
    assign o_res_req   = (state_q == img_filter_pkg::S_RES);
    assign o_pix_ack   = (state_q == img_filter_pkg::S_ACK);

endmodule

`default_nettype wire

//--- design/window_datapath.sv
`default_nettype none

`include "img_filter_defs.svh"

module window_datapath (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            i_advance,
    input  wire img_filter_pkg::col_taps_t i_taps,
    output img_filter_pkg::window_t        o_window,
    output logic                           o_win_valid,
    output logic                           o_frame_last
);

    // Position of the next pixel to arrive.
    logic [`CNT_W-1:0] col_q;
    logic [`CNT_W-1:0] row_q;

    // Position of the pixel most recently shifted into the window.
    logic [`CNT_W-1:0] pos_col_q;
    logic [`CNT_W-1:0] pos_row_q;

    logic col_wrap;
    logic row_wrap;

    // Index 0 is the newest column.
    img_filter_pkg::col_taps_t taps_sr [3];

    assign col_wrap = (col_q == `CNT_W'(`IMG_COLS - 1));
    assign row_wrap = (row_q == `CNT_W'(`IMG_ROWS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_q     <= '0;
            row_q     <= '0;
            pos_col_q <= '0;
            pos_row_q <= '0;
        end else if (i_advance) begin
            pos_col_q <= col_q;
            pos_row_q <= row_q;
            if (col_wrap) begin
                col_q <= '0;
                if (row_wrap) begin
                    row_q <= '0;
                end else begin
                    row_q <= row_q + 1'b1;
                end
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_advance) begin
            taps_sr[0] <= i_taps;
            taps_sr[1] <= taps_sr[0];
            taps_sr[2] <= taps_sr[1];
        end
    end

    always_comb begin
        o_window.p00 = taps_sr[2].top;
        o_window.p01 = taps_sr[1].top;
        o_window.p02 = taps_sr[0].top;
        o_window.p10 = taps_sr[2].mid;
        o_window.p11 = taps_sr[1].mid;
        o_window.p12 = taps_sr[0].mid;
        o_window.p20 = taps_sr[2].bot;
        o_window.p21 = taps_sr[1].bot;
        o_window.p22 = taps_sr[0].bot;
    end

    // The window is complete once two full columns and two full rows precede
    // the newest pixel. Rows from an earlier frame are never used then.
    assign o_win_valid = (pos_col_q >= `CNT_W'(2)) && (pos_row_q >= `CNT_W'(2));

    assign o_frame_last = (pos_col_q == `CNT_W'(`IMG_COLS - 1)) &&
                          (pos_row_q == `CNT_W'(`IMG_ROWS - 1));

endmodule

`default_nettype wire

//--- dv/img_filter_properties.sv
`default_nettype none

module img_filter_properties (
    input wire                          clk,
    input wire                          rst_n,
    input wire                          i_pix_req,
    input wire                          i_pix_ack,
    input wire                          i_res_req,
    input wire img_filter_pkg::result_t i_res,
    input wire                          i_res_ack
);

    timeunit 1ns;
    timeprecision 1ps;

    // The acknowledge only ever answers a pending request.
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(i_pix_ack) |-> i_pix_req)
        else $error("o_pix_ack rose without i_pix_req");

    res_held: assert property (@(posedge clk) disable iff (!rst_n)
        (i_res_req && !i_res_ack) |=> (i_res_req && $stable(i_res)))
        else $error("o_res_req or o_res changed before i_res_ack");

    res_drop_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(i_res_req) |-> $past(i_res_ack))
        else $error("o_res_req fell without i_res_ack");

    reset_idle: assert property (@(posedge clk)
        !rst_n |=> (!i_pix_ack && !i_res_req))
        else $error("handshake outputs not low after reset");

endmodule

bind img_filter_top img_filter_properties u_properties (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_pix_req (i_pix_req),
    .i_pix_ack (o_pix_ack),
    .i_res_req (o_res_req),
    .i_res     (o_res),
    .i_res_ack (i_res_ack)
);

`default_nettype wire

//--- dv/img_filter_tb.sv
`default_nettype none

`include "img_filter_defs.svh"

module img_filter_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PIX = `IMG_ROWS * `IMG_COLS;
    localparam int NUM_WIN = (`IMG_ROWS - 2) * (`IMG_COLS - 2);
    // Six and a half frames are sent in all, at well under 40 cycles a pixel.
    localparam int MAX_CYCLES = 7 * NUM_PIX * 40;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    pix_req;
    logic [`PIX_W-1:0]       pix;
    logic                    pix_ack;
    logic                    res_req;
    img_filter_pkg::result_t res;
    logic                    res_ack;

    logic [`PIX_W-1:0]       frame_mem [`IMG_ROWS][`IMG_COLS];
    img_filter_pkg::result_t exp_q [$];
    logic [7:0]              lfsr_q = 8'd30;

    int errors = 0;
    int errors_at_start = 0;
    int checks = 0;
    int tests_run = 0;
    int results_seen = 0;
    int lasts_seen = 0;
    int cycle_cnt = 0;
    bit sink_random = 1'b0;

    img_filter_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_pix_req (pix_req),
        .i_pix     (pix),
        .o_pix_ack (pix_ack),
        .o_res_req (res_req),
        .o_res     (res),
        .i_res_ack (res_ack)
    );

    always #50 clk = ~clk;

    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = (v << 1) | lfsr_q[0];
        end
        return v;
    endfunction

    // Weight is (2 - |dr|) * (2 - |dc|), giving 1-2-1 / 2-4-2 / 1-2-1.
    function automatic logic [`PIX_W-1:0] gauss_ref(input int r, input int c);
        int sum;
        sum = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                sum += int'(frame_mem[r + dr][c + dc]) * (2 - (dr < 0 ? -dr : dr))
                       * (2 - (dc < 0 ? -dc : dc));
            end
        end
        return sum / 16;
    endfunction

    function automatic bit is_frame_last(input int r, input int c);
        return (r == `IMG_ROWS - 2) && (c == `IMG_COLS - 2);
    endfunction

    function automatic int windows_in(input int n);
        int cnt;
        cnt = 0;
        for (int i = 0; i < n; i++) begin
            if (i / `IMG_COLS >= 2 && i % `IMG_COLS >= 2) begin
                cnt++;
            end
        end
        return cnt;
    endfunction

    task automatic fill_frame(input bit use_lfsr, input logic [`PIX_W-1:0] value);
        for (int r = 0; r < `IMG_ROWS; r++) begin
            for (int c = 0; c < `IMG_COLS; c++) begin
                frame_mem[r][c] = use_lfsr ? `PIX_W'(rand_bits(`PIX_W)) : value;
            end
        end
    endtask

    task automatic wait_pix_ack(input logic level);
        do begin
            @(negedge clk);
        end while (pix_ack !== level);
    endtask

    // A pixel at (r, c) completes the window centred one row and column back.
    task automatic send_pixel(input int r, input int c);
        img_filter_pkg::result_t expected;
        if (r >= 2 && c >= 2) begin
            expected.data = gauss_ref(r - 1, c - 1);
            expected.last = is_frame_last(r - 1, c - 1);
            exp_q.push_back(expected);
        end
        @(posedge clk);
        pix_req <= 1'b1;
        pix     <= frame_mem[r][c];
        wait_pix_ack(1'b1);
        if (exp_q.size() != 0) begin
            $display("error: pixel (%0d,%0d) acknowledged before its result", r, c);
            errors++;
        end
        @(posedge clk);
        pix_req <= 1'b0;
        wait_pix_ack(1'b0);
    endtask

    task automatic send_pixels(input int count);
        for (int i = 0; i < count; i++) begin
            send_pixel(i / `IMG_COLS, i % `IMG_COLS);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic start_test();
        results_seen    = 0;
        lasts_seen      = 0;
        errors_at_start = errors;
    endtask

    task automatic finish_test(input string name, input int exp_results, input int exp_lasts);
        tests_run++;
        checks += 3;
        if (exp_q.size() != 0) begin
            $display("error: %0d expected results never arrived", exp_q.size());
            errors++;
        end
        if (results_seen != exp_results) begin
            $display("mismatch o_res count: expected 0x%0h got 0x%0h", exp_results,
                     results_seen);
            errors++;
        end
        if (lasts_seen != exp_lasts) begin
            $display("mismatch o_res.last count: expected 0x%0h got 0x%0h", exp_lasts,
                     lasts_seen);
            errors++;
        end
        $display("test %0d %s: %0d results, %0d errors", tests_run, name, results_seen,
                 errors - errors_at_start);
    endtask

    initial begin : compare_results
        logic                    req_prev;
        img_filter_pkg::result_t expected;
        req_prev = 1'b0;
        forever begin
            @(negedge clk);
            if (res_req && pix_ack) begin
                $display("error: pixel acknowledged while a result is pending");
                errors++;
            end
            if (res_req && !req_prev) begin
                results_seen++;
                checks++;
                if (res.last) begin
                    lasts_seen++;
                end
                if (exp_q.size() == 0) begin
                    $display("error: result 0x%0h arrived when none was expected", res.data);
                    errors++;
                end else begin
                    expected = exp_q.pop_front();
                    if (res.data !== expected.data) begin
                        $display("mismatch o_res.data: expected 0x%0h got 0x%0h",
                                 expected.data, res.data);
                        errors++;
                    end
                    if (res.last !== expected.last) begin
                        $display("mismatch o_res.last: expected 0x%0h got 0x%0h",
                                 expected.last, res.last);
                        errors++;
                    end
                end
            end
            req_prev = res_req;
        end
    end

    initial begin : result_sink
        int delay;
        forever begin
            do begin
                @(negedge clk);
            end while (res_req !== 1'b1);
            delay = sink_random ? rand_bits(4) : 0;
            repeat (delay) @(posedge clk);
            @(posedge clk);
            res_ack <= 1'b1;
            do begin
                @(negedge clk);
            end while (res_req !== 1'b0);
            @(posedge clk);
            res_ack <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("error: timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin : run_tests
        rst_n   <= 1'b0;
        pix_req <= 1'b0;
        pix     <= '0;
        res_ack <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // A flat image stays flat because the weights sum to 16.
        start_test();
        fill_frame(1'b0, `PIX_W'(8'hA7));
        send_pixels(NUM_PIX);
        finish_test("constant image", NUM_WIN, 1);

        start_test();
        fill_frame(1'b1, '0);
        send_pixels(NUM_PIX);
        finish_test("random frame", NUM_WIN, 1);

        start_test();
        fill_frame(1'b1, '0);
        send_pixels(NUM_PIX);
        fill_frame(1'b1, '0);
        send_pixels(NUM_PIX);
        finish_test("two frames with last flag", 2 * NUM_WIN, 2);

        start_test();
        sink_random = 1'b1;
        fill_frame(1'b1, '0);
        send_pixels(NUM_PIX);
        sink_random = 1'b0;
        finish_test("back-pressure", NUM_WIN, 1);

        start_test();
        fill_frame(1'b1, '0);
        send_pixels(NUM_PIX / 2 + 3);
        apply_reset();
        fill_frame(1'b1, '0);
        send_pixels(NUM_PIX);
        finish_test("reset mid-frame", windows_in(NUM_PIX / 2 + 3) + NUM_WIN, 1);

        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+design
design/img_filter_pkg.sv
design/line_buffer.sv
design/window_datapath.sv
design/window_ctrl.sv
design/gauss_filter.sv
design/img_filter_top.sv
dv/img_filter_properties.sv
dv/img_filter_tb.sv
